// ==== Makefile ====
# Verilator build and run of the router adapter testbench.

SIM = obj_dir/Vtb_wh_router_adapter
SRC = $(shell grep -v '^+' filelist.f)

.PHONY: run clean

run: $(SIM)
	-./$(SIM) +verilator+error+limit+100 > sim.log 2>&1
	cat sim.log
	grep -q -F '** PASS **' sim.log

$(SIM): filelist.f $(SRC)
	verilator --binary --timing --assert --top-module tb_wh_router_adapter -f filelist.f

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
hw/wh_link_pkg.sv
hw/wh_packet_pkg.sv
hw/wh_adapter_in.sv
hw/wh_adapter_out.sv
hw/wh_router_adapter.sv
verification/wh_adapter_properties.sv
verification/tb_wh_router_adapter.sv

// ==== hw/wh_adapter_in.sv ====
/*
 * Send path of the router adapter.
 * Accepts a whole packet on valid/ready and sends it as a header flit
 * followed by len body flits over a ready-and link.
 */

`timescale 1ns/1ps

module wh_adapter_in (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  wh_packet_pkg::packet_s packet_i,
  input  logic                   v_i,
  output logic                   ready_o,

  input  wh_link_pkg::link_s     link_i,
  output wh_link_pkg::link_s     link_o
);

  // The latched packet viewed as a row of flits, flit 0 in the low bits.
  logic [wh_packet_pkg::max_flits-1:0][wh_link_pkg::flit_width-1:0] flits_w;

  wh_packet_pkg::packet_s              pkt_q;
  logic [wh_packet_pkg::len_width-1:0] idx_q;
  logic                                busy_q;

  logic accept_w;
  logic flit_sent_w;
  logic last_flit_w;

  assign accept_w    = v_i & ready_o;
  assign flit_sent_w = busy_q & link_i.ready_and_rev; // router took the shown flit.
  assign last_flit_w = (idx_q == pkt_q.len);         // header is index 0.

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (accept_w) begin
      busy_q <= 1'b1;
      idx_q  <= '0;
    end else if (flit_sent_w) begin
      if (last_flit_w) begin
        busy_q <= 1'b0; // ready_o returns in the next cycle.
        idx_q  <= '0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // Only written on acceptance, so the flits hold still through stalls.
  always_ff @(posedge clk_i) begin
    if (accept_w) begin
      pkt_q <= packet_i;
    end
  end

  assign flits_w = pkt_q;

  assign ready_o = ~busy_q;

  assign link_o.data          = flits_w[idx_q];
  assign link_o.v             = busy_q;
  assign link_o.ready_and_rev = 1'b0; // the receive path owns this field.

endmodule

// ==== hw/wh_adapter_out.sv ====
/*
 * Receive path of the router adapter.
 * Gathers a header flit and its body flits from the link into a packet
 * and holds it on valid until the consumer takes it with yumi.
 */

`timescale 1ns/1ps

module wh_adapter_out (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  wh_link_pkg::link_s     link_i,
  output wh_link_pkg::link_s     link_o,

  output wh_packet_pkg::packet_s packet_o,
  output logic                   v_o,
  input  logic                   yumi_i
);

  localparam int pad_width = wh_packet_pkg::packet_width - wh_link_pkg::flit_width;

  // Assembly register as a row of flits, flit 0 in the low bits.
  logic [wh_packet_pkg::max_flits-1:0][wh_link_pkg::flit_width-1:0] asm_q;

  wh_packet_pkg::packet_s              hdr_w;
  logic [wh_packet_pkg::len_width-1:0] cnt_q;
  logic [wh_packet_pkg::len_width-1:0] exp_q;
  logic                                full_q;

  logic flit_recv_w;
  logic is_hdr_w;
  logic done_w;

  // The header flit is the low slice of a packet, so len can be read
  // through the packet struct once the flit is widened.
  assign hdr_w = {{pad_width{1'b0}}, link_i.data};

  assign flit_recv_w = link_i.v & ~full_q;
  assign is_hdr_w    = (cnt_q == '0);
  assign done_w      = is_hdr_w ? (hdr_w.len == '0) : (cnt_q == exp_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      cnt_q  <= '0;
      exp_q  <= '0;
    end else begin
      if (flit_recv_w) begin
        if (is_hdr_w) begin
          exp_q <= hdr_w.len;
        end
        if (done_w) begin
          full_q <= 1'b1; // stops the link until yumi.
          cnt_q  <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
      if (yumi_i) begin
        full_q <= 1'b0;
      end
    end
  end

  // Clearing at the header leaves unsent payload flits at zero.
  always_ff @(posedge clk_i) begin
    if (flit_recv_w) begin
      if (is_hdr_w) begin
        asm_q    <= '0;
        asm_q[0] <= link_i.data;
      end else begin
        asm_q[cnt_q] <= link_i.data;
      end
    end
  end

  assign packet_o = asm_q;
  assign v_o      = full_q;

  assign link_o.data          = '0;   // the send path owns the flit fields.
  assign link_o.v             = 1'b0;
  assign link_o.ready_and_rev = ~full_q;

endmodule

// ==== hw/wh_link_pkg.sv ====
/*
 * Link-side definitions for the wormhole router port:
 *   flit_width  width of one flit on the link
 *   link_s      one direction of a ready-and link (data, valid, reverse ready)
 */

package wh_link_pkg;

  // one flit carries a 16-bit slice of a packet.
  localparam int flit_width = 16;

  // A link bundle as seen from one side of the port.
  // data and v travel forward with the flit, while ready_and_rev
  // is the receiver's readiness for flits moving the opposite way.
  typedef struct packed {
    logic [flit_width-1:0] data;          // flit payload.
    logic                  v;             // flit valid.
    logic                  ready_and_rev; // ready for the reverse direction.
  } link_s;

endpackage

// ==== hw/wh_packet_pkg.sv ====
/*
 * Packet-side definitions for the router adapter:
 *   field widths for cord, len and payload
 *   packet_s    the whole packet {payload, len, cord}
 *   max_flits   number of flits a full packet occupies
 */

package wh_packet_pkg;

  localparam int cord_width        = 4;  // destination coordinate.
  localparam int len_width         = 2;  // body flits following the header.
  localparam int max_payload_width = 42;

  localparam int packet_width = max_payload_width + len_width + cord_width;

  // The packet splits into whole flits with no padding.
  localparam int max_flits = packet_width / wh_link_pkg::flit_width;

  // cord sits in the low bits so it always arrives in the header flit,
  // together with len and the lowest payload bits.
  typedef struct packed {
    logic [max_payload_width-1:0] payload;
    logic [len_width-1:0]         len;  // counts body flits, 0 to 2.
    logic [cord_width-1:0]        cord;
  } packet_s;

endpackage

// ==== hw/wh_router_adapter.sv ====
/*
 * Full-duplex adapter between a packet port and one wormhole router link.
 * Joins the send and receive paths and merges their link outputs.
 */

`timescale 1ns/1ps

module wh_router_adapter (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  input  wh_packet_pkg::packet_s packet_i,
  input  logic                   v_i,
  output logic                   ready_o,

  input  wh_link_pkg::link_s     link_i,  // from the router.
  output wh_link_pkg::link_s     link_o,  // to the router.

  output wh_packet_pkg::packet_s packet_o,
  output logic                   v_o,
  input  logic                   yumi_i
);

  wh_link_pkg::link_s send_link_w;
  wh_link_pkg::link_s recv_link_w;

  wh_adapter_in i_adapter_in (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .packet_i (packet_i),
    .v_i      (v_i),
    .ready_o  (ready_o),
    .link_i   (link_i),
    .link_o   (send_link_w)
  );

  wh_adapter_out i_adapter_out (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .link_i   (link_i),
    .link_o   (recv_link_w),
    .packet_o (packet_o),
    .v_o      (v_o),
    .yumi_i   (yumi_i)
  );

  // Flits come from the send path, reverse ready from the receive path.
  assign link_o.data          = send_link_w.data;
  assign link_o.v             = send_link_w.v;
  assign link_o.ready_and_rev = recv_link_w.ready_and_rev;

endmodule

// ==== verification/tb_wh_router_adapter.sv ====
/*
 * Testbench for the router adapter.
 * Loops the link output back to the link input through a stall gate,
 * sends random packets of every length, takes them back with random
 * yumi delay and compares each one with a queue of expected packets.
 */

`timescale 1ns/1ps

module tb_wh_router_adapter;

  localparam int clk_period     = 100;
  localparam int reset_cycles   = 16;
  localparam int drive_delay    = 1;
  localparam int directed_count = 9;   // three of each length.
  localparam int stall_count    = 40;
  localparam int yumi_count     = 40;
  localparam int stream_count   = 300;
  localparam int total_packets  = directed_count + stall_count + yumi_count + stream_count;
  localparam int cycle_limit    = reset_cycles + total_packets * 20;

  logic                   clk_i;
  logic                   rst_n_i;
  wh_packet_pkg::packet_s packet_i;
  logic                   v_i;
  logic                   ready_o;
  wh_link_pkg::link_s     link_i;
  wh_link_pkg::link_s     link_o;
  wh_packet_pkg::packet_s packet_o;
  logic                   v_o;
  logic                   yumi_i;

  logic stall;
  logic stall_en  = 1'b0;
  int   gap_odds  = 1;  // idle cycles before a packet are drawn below this.
  int   yumi_odds = 1;  // a waiting packet is taken with chance 1 in yumi_odds.
  int   cycle_count = 0;

  // each process offsets the base seed so the streams stay apart.
  integer send_seed  = 32'habbb;
  integer stall_seed = 32'habbb + 32'd1;
  integer yumi_seed  = 32'habbb + 32'd2;

  wh_packet_pkg::packet_s expected_q[$];

  wh_router_adapter i_dut (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .packet_i (packet_i),
    .v_i      (v_i),
    .ready_o  (ready_o),
    .link_i   (link_i),
    .link_o   (link_o),
    .packet_o (packet_o),
    .v_o      (v_o),
    .yumi_i   (yumi_i)
  );

  // The loopback hides the flit and the reverse ready alike in a stalled cycle.
  assign link_i = '{data:          link_o.data,
                    v:             link_o.v & ~stall,
                    ready_and_rev: link_o.ready_and_rev & ~stall};

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic expect_bit(input string name, input logic actual, input logic expected);
    assert (actual === expected)
      else abort_run($sformatf("** Error at %0d ns: %s expected %b, actual %b",
                               $time, name, expected, actual));
  endtask

  // Flit k holds packet bits 16k to 16k+15, and flits past len never travel.
  function automatic wh_packet_pkg::packet_s sent_part(input wh_packet_pkg::packet_s p);
    logic [wh_packet_pkg::packet_width-1:0] bits;
    int                                     sent_bits;
    bits      = p;
    sent_bits = (int'(p.len) + 1) * wh_link_pkg::flit_width;
    for (int i = 0; i < wh_packet_pkg::packet_width; i++) begin
      if (i >= sent_bits) begin
        bits[i] = 1'b0;
      end
    end
    return bits;
  endfunction

  task automatic make_packet(input logic [wh_packet_pkg::len_width-1:0] len,
                             output wh_packet_pkg::packet_s p);
    logic [63:0] bits;
    bits      = {$random(send_seed), $random(send_seed)};
    p.cord    = bits[wh_packet_pkg::cord_width-1:0];
    p.len     = len;
    p.payload = bits[63 -: wh_packet_pkg::max_payload_width];
  endtask

  // waits a random gap, then holds the packet on v_i until it is accepted.
  task automatic send_packet(input wh_packet_pkg::packet_s p);
    int unsigned gap;
    logic        taken;
    gap   = $unsigned($random(send_seed)) % gap_odds;
    taken = 1'b0;
    repeat (gap) begin
      @(posedge clk_i);
      #(drive_delay);
    end
    v_i      = 1'b1;
    packet_i = p;
    while (!taken) begin
      @(negedge clk_i);
      taken = ready_o;  // the handshake of the coming edge.
      @(posedge clk_i);
      #(drive_delay);
    end
    v_i = 1'b0;
  endtask

  task automatic wait_drained();
    while (expected_q.size() != 0 || v_o) begin
      @(posedge clk_i);
      #(drive_delay);
    end
  endtask

  task automatic stream_packets(input int count);
    wh_packet_pkg::packet_s              p;
    logic [wh_packet_pkg::len_width-1:0] len;
    int unsigned                         r;
    for (int n = 0; n < count; n++) begin
      r   = $unsigned($random(send_seed)) % wh_packet_pkg::max_flits;
      len = r[wh_packet_pkg::len_width-1:0];
      make_packet(len, p);
      send_packet(p);
    end
    wait_drained();
  endtask

  initial begin : stall_gate
    stall = 1'b0;
    forever begin
      @(posedge clk_i);
      #(drive_delay);
      stall = stall_en && (($unsigned($random(stall_seed)) % 4) == 0);
    end
  end

  initial begin : yumi_driver
    yumi_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #(drive_delay);
      yumi_i = v_o && (($unsigned($random(yumi_seed)) % yumi_odds) == 0);
    end
  end

  // Handshakes are sampled half a cycle before the edge that completes them.
  always @(negedge clk_i) begin : scoreboard
    wh_packet_pkg::packet_s expected;
    if (rst_n_i) begin
      if (v_i && ready_o) begin
        expected_q.push_back(sent_part(packet_i));
      end
      if (yumi_i) begin
        assert (expected_q.size() != 0)
          else abort_run("a packet arrived on the receive side that was never sent");
        expected = expected_q.pop_front();
        assert (packet_o == expected)
          else abort_run($sformatf("** Error at %0d ns: packet_o expected %h, actual %h",
                                   $time, expected, packet_o));
      end
    end
  end

  always @(negedge clk_i) begin : property_watch
    assert (i_dut.i_properties.error_count == 0)
      else abort_run("a protocol assertion on the adapter ports failed");
  end

  always @(posedge clk_i) begin : watchdog
    cycle_count++;
    assert (cycle_count < cycle_limit)
      else abort_run($sformatf("the run did not finish within %0d cycles", cycle_limit));
  end

  initial begin : main
    wh_packet_pkg::packet_s              p;
    logic [wh_packet_pkg::len_width-1:0] len;
    int unsigned                         r;

    rst_n_i  = 1'b0;
    v_i      = 1'b0;
    packet_i = '0;
    repeat (reset_cycles) @(posedge clk_i);
    #(drive_delay);
    rst_n_i = 1'b1;

    @(negedge clk_i);
    expect_bit("ready_o", ready_o, 1'b1);
    expect_bit("link_o.ready_and_rev", link_o.ready_and_rev, 1'b1);
    expect_bit("v_o", v_o, 1'b0);
    expect_bit("link_o.v", link_o.v, 1'b0);
    @(posedge clk_i);
    #(drive_delay);

    // Every length goes over a quiet link and each packet is taken at once.
    for (int n = 0; n < directed_count; n++) begin
      r   = n % wh_packet_pkg::max_flits;
      len = r[wh_packet_pkg::len_width-1:0];
      make_packet(len, p);
      send_packet(p);
    end
    wait_drained();

    stall_en = 1'b1;  // link stalls only.
    stream_packets(stall_count);

    stall_en  = 1'b0; // slow consumer only.
    yumi_odds = 4;
    stream_packets(yumi_count);

    stall_en  = 1'b1; // everything at once.
    gap_odds  = 3;
    yumi_odds = 3;
    stream_packets(stream_count);

    if (expected_q.size() == 0 && !v_o) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run("packets were left over at the end of the run");
    end
  end

endmodule

// ==== verification/wh_adapter_properties.sv ====
/*
 * Protocol assertions for the router adapter, bound into its top level:
 * flit stability under link stalls, packet stability until yumi,
 * yumi only with valid, send path ready and valid apart, idle after reset.
 */

`timescale 1ns/1ps

module wh_adapter_properties (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input logic                   ready_o,
  input wh_link_pkg::link_s     link_i,
  input wh_link_pkg::link_s     link_o,
  input wh_packet_pkg::packet_s packet_o,
  input logic                   v_o,
  input logic                   yumi_i
);

  int unsigned error_count = 0; // failures so far, watched by the testbench.

  link_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_o.v && !link_i.ready_and_rev |=> link_o.v && $stable(link_o.data))
    else begin
      $error("flit valid or data changed while the link was stalled");
      error_count++;
    end

  packet_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    v_o && !yumi_i |=> v_o && $stable(packet_o))
    else begin
      $error("received packet changed or vanished before yumi");
      error_count++;
    end

  yumi_valid_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o)
    else begin
      $error("yumi without a valid packet");
      error_count++;
    end

  send_busy_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    link_o.v |-> !ready_o)
    else begin
      $error("send path ready while a flit is still on the link");
      error_count++;
    end

  // Both valids come out of reset low.
  reset_idle_a: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !link_o.v && !v_o)
    else begin
      $error("a valid was high in the first cycle after reset");
      error_count++;
    end

endmodule

bind wh_router_adapter wh_adapter_properties i_properties (
  .clk_i    (clk_i),
  .rst_n_i  (rst_n_i),
  .ready_o  (ready_o),
  .link_i   (link_i),
  .link_o   (link_o),
  .packet_o (packet_o),
  .v_o      (v_o),
  .yumi_i   (yumi_i)
);
